//--- dv/i2s_tests.txt
// kind a b c d : 1 = mode (a audio_test, b hold cycles), 2 = pair (a left, b right,
// c expected left, d expected right), 3 = underrun (a zero pairs expected), 0 = end
1 0 bb8 0 0
2 123456 abcdef 123456 abcdef
2 000001 800000 000001 800000
2 7fffff fffffe 7fffff fffffe
2 a5a5a5 5a5a5a a5a5a5 5a5a5a
2 0f0f0f f0f0f0 0f0f0f f0f0f0
2 111111 222222 111111 222222
2 333333 444444 333333 444444
2 555555 666666 555555 666666
2 777777 888888 777777 888888
1 1 0 0 0
2 010203 040506 666aaa 555999
2 0a0b0c 0d0e0f 666aaa 555999
2 fedcba 987654 666aaa 555999
2 000000 000000 666aaa 555999
2 c0ffee 0badf0 666aaa 555999
2 112233 445566 666aaa 555999
2 778899 aabbcc 666aaa 555999
2 ddeeff 102030 666aaa 555999
1 0 0 0 0
2 100001 200002 100001 200002
2 300003 400004 300003 400004
2 500005 600006 500005 600006
2 700007 800008 700007 800008
2 900009 a0000a 900009 a0000a
2 b0000b c0000c b0000b c0000c
2 d0000d e0000e d0000d e0000e
2 f0000f 0f0f00 f0000f 0f0f00
3 2 0 0 0
1 0 0 0 0
2 246802 135791 246802 135791
2 fedcb0 0abcde fedcb0 0abcde
2 800001 7ffffe 800001 7ffffe
2 cccccc 333333 cccccc 333333
2 999999 666666 999999 666666
2 aaaaaa 555555 aaaaaa 555555
2 efefef fefefe efefef fefefe
2 121212 343434 121212 343434
0 0 0 0 0

//--- dv/i2s_tx_tb.sv
module i2s_tx_tb;

    import i2s_pkg::*;

    localparam int max_records = 256;

    logic        clk;
    logic        reset;
    logic        audio_en;
    logic        audio_test;
    pcm_in_t     pcm_left;
    pcm_in_t     pcm_right;
    logic        credit_left;
    logic        credit_right;
    i2s_line_t   i2s;
    logic        underrun;

    logic [31:0] tests [0:max_records*5-1];      // five words per record
    pcm_sample_t exp_left_q[$];
    pcm_sample_t exp_right_q[$];
    logic        under_left_q[$];                // underrun expected with this word
    logic        under_right_q[$];
    int          wr_left, wr_right, cred_left, cred_right;
    int          dec_data_left, dec_data_right;
    int          right_phase_writes, pairs_in_phase, hold_cycles;
    int          err_value, err_proto, cycle, limit;
    logic        bclk_prev, lr_prev, collecting, left_seen;
    chan_t       slot_chan;
    int          bit_idx;
    int          bclk_gap;                       // clk cycles since the last rising bclk
    int          slot_len;                       // rising bclk edges since the lrclk change
    pcm_sample_t word;

    i2s_tx_top UUT (
        .clk          (clk),
        .reset        (reset),
        .audio_en     (audio_en),
        .audio_test   (audio_test),
        .pcm_left     (pcm_left),
        .pcm_right    (pcm_right),
        .credit_left  (credit_left),
        .credit_right (credit_right),
        .i2s          (i2s),
        .underrun     (underrun)
    );

    always #20 clk = ~clk;

    task automatic check_sample(input chan_t chan, input pcm_sample_t got, input pcm_sample_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s word got %h expected %h", $time, chan.name(), got, exp);
            err_value++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
            err_value++;
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_value++;
        end
    endtask

    // one decoded slot against the head of its queue
    task automatic take_decoded_word(input chan_t chan, input pcm_sample_t got);
        logic under;
        if (chan == chan_left) begin
            left_seen <= 1'b1;
            if (exp_left_q.size() == 0) begin
                $display("left word %h appeared on the line with none pending", got);
                err_proto++;
            end else begin
                under = under_left_q.pop_front();
                check_sample(chan, got, exp_left_q.pop_front());
                check_flag("underrun", underrun, under);
                if (!under) dec_data_left++;
            end
        end else if (left_seen) begin                 // first right slot carries no data
            if (exp_right_q.size() == 0) begin
                $display("right word %h appeared on the line with none pending", got);
                err_proto++;
            end else begin
                under = under_right_q.pop_front();
                check_sample(chan, got, exp_right_q.pop_front());
                if (!under) dec_data_right++;
            end
        end
    endtask

    task automatic wait_drain();
        while (exp_left_q.size() != 0 || exp_right_q.size() != 0) @(posedge clk);
        compare_count("left credits", cred_left, wr_left);
        compare_count("right credits", cred_right, wr_right);
        compare_count("left data words", dec_data_left, cred_left);
        compare_count("right data words", dec_data_right, cred_right);
    endtask

    task automatic restart_line(input logic test_mode, input int hold);
        @(posedge clk);
        audio_en   <= 1'b0;
        audio_test <= test_mode;
        repeat (4) @(posedge clk);
        check_flag("underrun", underrun, 1'b0);
        audio_en <= 1'b1;
        right_phase_writes <= 0;
        pairs_in_phase = 0;
        hold_cycles = hold;
    endtask

    task automatic write_pair(input pcm_sample_t l, input pcm_sample_t r,
                              input pcm_sample_t exp_l, input pcm_sample_t exp_r);
        if (pairs_in_phase == start_level - 1 && hold_cycles > 0) begin
            repeat (hold_cycles) @(posedge clk);     // line must stay quiet here
        end
        @(posedge clk);
        while (wr_left - cred_left >= fifo_depth || wr_right - cred_right >= fifo_depth) begin
            @(posedge clk);
        end
        pcm_left  <= '{sample: l, valid: 1'b1};
        pcm_right <= '{sample: r, valid: 1'b1};
        wr_left++;
        wr_right++;
        right_phase_writes <= right_phase_writes + 1;
        pairs_in_phase++;
        exp_left_q.push_back(exp_l);
        exp_right_q.push_back(exp_r);
        under_left_q.push_back(1'b0);
        under_right_q.push_back(1'b0);
        @(posedge clk);
        pcm_left.valid  <= 1'b0;
        pcm_right.valid <= 1'b0;
    endtask

    // sdata sampled at rising bclk, msb one bclk after the lrclk change
    always @(posedge clk) begin
        bclk_prev <= i2s.bclk;
        bclk_gap  <= bclk_gap + 1;
        if (!audio_en) begin
            lr_prev    <= 1'b0;
            collecting <= 1'b0;
            left_seen  <= 1'b0;
            slot_len   <= 0;
        end else if (i2s.bclk && !bclk_prev) begin
            bclk_gap <= 1;
            if (slot_len != 0) compare_count("bclk period", bclk_gap, bclk_div);
            if (!collecting) check_flag("padding bit", i2s.sdata, 1'b0);   // bits after the 24th
            if (i2s.lrclk != lr_prev) begin
                if (slot_len != 0) compare_count("slot length", slot_len, slot_bits);
                slot_len   <= 1;
                lr_prev    <= i2s.lrclk;
                collecting <= 1'b1;
                bit_idx    <= 0;
                slot_chan  <= i2s.lrclk ? chan_right : chan_left;
            end else begin
                if (slot_len != 0) slot_len <= slot_len + 1;
                if (collecting) begin
                    word    <= {word[sample_width-2:0], i2s.sdata};
                    bit_idx <= bit_idx + 1;
                    if (bit_idx == sample_width - 1) begin
                        collecting <= 1'b0;
                        take_decoded_word(slot_chan, {word[sample_width-2:0], i2s.sdata});
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (credit_left) cred_left <= cred_left + 1;
        if (credit_right) cred_right <= cred_right + 1;
        if (cred_left > wr_left || cred_right > wr_right) begin
            $display("more credits came back than samples were written, at time %0t", $time);
            err_proto++;
        end
        if (audio_en && right_phase_writes < start_level && (i2s.lrclk || i2s.sdata)) begin
            $display("line active before the start level was written, at time %0t", $time);
            err_proto++;
        end
        if (limit > 0 && cycle > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        int n;
        int hold_total;
        logic [31:0] kind;
        clk = 1'b0;
        reset = 1'b1;
        audio_en = 1'b0;
        audio_test = 1'b0;
        pcm_left = '0;
        pcm_right = '0;
        limit = 0;
        $readmemh("dv/i2s_tests.txt", tests);
        n = 0;
        hold_total = 0;
        while (n < max_records && (tests[n*5] == 1 || tests[n*5] == 2 || tests[n*5] == 3)) begin
            if (tests[n*5] == 1) hold_total += tests[n*5+2];
            n++;
        end
        limit = n * 512 * 2 + hold_total + 8192;     // reset and fill margin
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int idx = 0; idx < n; idx++) begin
            kind = tests[idx*5];
            if (kind == 1) begin
                wait_drain();
                restart_line(tests[idx*5+1][0], tests[idx*5+2]);
            end else if (kind == 2) begin
                write_pair(tests[idx*5+1][23:0], tests[idx*5+2][23:0],
                           tests[idx*5+3][23:0], tests[idx*5+4][23:0]);
            end else begin
                wait_drain();                        // producer stalls, fifos run dry
                repeat (tests[idx*5+1]) begin
                    exp_left_q.push_back('0);
                    exp_right_q.push_back('0);
                    under_left_q.push_back(1'b1);
                    under_right_q.push_back(1'b1);
                end
            end
        end
        wait_drain();
        @(posedge clk);
        audio_en <= 1'b0;
        repeat (4) @(posedge clk);
        check_flag("underrun", underrun, 1'b0);
        $display("value errors: %0d, protocol errors: %0d", err_value, err_proto);
        if (err_value == 0 && err_proto == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- logic/bit_clock_gen.sv
module bit_clock_gen (
    input  logic clk,
    input  logic reset,
    input  logic audio_en,
    output logic bclk,
    output logic bit_strobe
);

    import i2s_pkg::*;

    logic [phase_width-1:0] phase;
    logic [phase_width-1:0] phase_next;

    assign phase_next = phase + 1'b1;                 // wraps every bclk_div cycles

    // bclk high in the first half of the period, low in the second
    always_ff @(posedge clk) begin
        if (reset || !audio_en) begin
            phase      <= '0;
            bclk       <= 1'b0;
            bit_strobe <= 1'b0;
        end else begin
            phase      <= phase_next;
            bclk       <= !phase_next[phase_width-1];
            bit_strobe <= (phase_next == strobe_phase);   // cycle of the falling edge
        end
    end

endmodule

//--- logic/i2s_pkg.sv
package i2s_pkg;

    localparam int sample_width = 24;                 // pcm word width
    localparam int slot_bits    = 32;                 // bclk periods per channel slot
    localparam int frame_bits   = 2 * slot_bits;      // left slot plus right slot
    localparam int bclk_div     = 8;                  // clk cycles per bclk period
    localparam int fifo_depth   = 16;                 // entries per channel, also credits
    localparam int start_level  = 8;                  // right fill that starts the line

    localparam int ptr_width     = $clog2(fifo_depth);
    localparam int phase_width   = $clog2(bclk_div);
    localparam int bit_cnt_width = $clog2(frame_bits);

    // bclk falls when the phase reaches half a period
    localparam logic [phase_width-1:0] strobe_phase = phase_width'(bclk_div / 2);

    localparam logic [bit_cnt_width-1:0] last_left_bit  = bit_cnt_width'(slot_bits - 1);
    localparam logic [bit_cnt_width-1:0] last_right_bit = bit_cnt_width'(frame_bits - 1);

    localparam logic [sample_width-1:0] test_pattern_left  = 24'h666aaa;
    localparam logic [sample_width-1:0] test_pattern_right = 24'h555999;

    typedef logic [sample_width-1:0] pcm_sample_t;

    typedef struct packed {
        pcm_sample_t sample;
        logic        valid;                           // one-cycle write strobe
    } pcm_in_t;

    typedef struct packed {
        logic bclk;
        logic lrclk;
        logic sdata;
    } i2s_line_t;

    typedef enum logic {chan_left, chan_right} chan_t;

    typedef enum logic [1:0] {ser_idle, ser_fill, ser_run} ser_state_t;

    typedef logic [$clog2(fifo_depth + 1)-1:0] level_t;   // 0 to fifo_depth

endpackage

//--- logic/i2s_serializer.sv
module i2s_serializer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 audio_en,
    input  logic                 audio_test,
    input  logic                 bit_strobe,
    input  logic                 bclk,
    input  i2s_pkg::pcm_sample_t left_head,
    input  i2s_pkg::pcm_sample_t right_head,
    input  logic                 left_empty,
    input  logic                 right_empty,
    input  i2s_pkg::level_t      right_level,
    output logic                 left_rd,
    output logic                 right_rd,
    output i2s_pkg::i2s_line_t   i2s,
    output logic                 underrun
);

    import i2s_pkg::*;

    ser_state_t             state;
    logic [bit_cnt_width-1:0] bit_cnt;
    logic                   lrclk;
    logic                   lrclk_dly;
    logic [slot_bits-1:0]   shift_reg;
    pcm_sample_t            left_hold;
    pcm_sample_t            right_hold;
    pcm_sample_t            load_word;
    chan_t                  load_chan;
    logic                   run_strobe;
    logic                   slot_start;
    logic                   left_pop;
    logic                   right_pop;

    assign run_strobe = (state == ser_run) && bit_strobe;
    assign slot_start = (lrclk != lrclk_dly);         // first strobe after an lrclk change
    assign load_chan  = lrclk ? chan_right : chan_left;
    assign left_pop   = run_strobe && (bit_cnt == last_left_bit);
    assign right_pop  = run_strobe && (bit_cnt == last_right_bit);

    always_comb begin
        if (load_chan == chan_left) begin
            load_word = audio_test ? test_pattern_left : left_hold;
        end else begin
            load_word = audio_test ? test_pattern_right : right_hold;
        end
    end

    // start control, waits for the right fifo to reach start_level
    always_ff @(posedge clk) begin
        if (reset || !audio_en) begin
            state <= ser_idle;
        end else begin
            case (state)
                ser_idle: state <= ser_fill;
                ser_fill: if (right_level >= level_t'(start_level)) state <= ser_run;
                default:  state <= ser_run;
            endcase
        end
    end

    // frame counter, lrclk and fifo pops
    always_ff @(posedge clk) begin
        if (reset || !audio_en) begin
            bit_cnt   <= '0;
            lrclk     <= 1'b0;
            lrclk_dly <= 1'b0;
            left_rd   <= 1'b0;
            right_rd  <= 1'b0;
            underrun  <= 1'b0;
        end else begin
            left_rd  <= left_pop && !left_empty;
            right_rd <= right_pop && !right_empty;
            if (run_strobe) begin
                bit_cnt   <= bit_cnt + 1'b1;          // wraps once per frame
                lrclk_dly <= lrclk;
            end
            if (left_pop) begin
                lrclk    <= 1'b1;
                underrun <= underrun || left_empty;   // sticky
            end
            if (right_pop) begin
                lrclk    <= 1'b0;
                underrun <= underrun || right_empty;
            end
        end
    end

    // popped word waits here until its slot starts
    always_ff @(posedge clk) begin
        if (reset || !audio_en) begin
            left_hold  <= '0;
            right_hold <= '0;
        end else begin
            if (left_pop) left_hold <= left_empty ? '0 : left_head;
            if (right_pop) right_hold <= right_empty ? '0 : right_head;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !audio_en) begin
            shift_reg <= '0;
        end else if (run_strobe) begin
            if (slot_start) begin
                shift_reg <= {load_word, {(slot_bits - sample_width){1'b0}}};
            end else begin
                shift_reg <= {shift_reg[slot_bits-2:0], 1'b0};   // msb first
            end
        end
    end

    assign i2s.bclk  = bclk;
    assign i2s.lrclk = lrclk;
    assign i2s.sdata = shift_reg[slot_bits-1];

endmodule

//--- logic/i2s_tx_top.sv
module i2s_tx_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               audio_en,
    input  logic               audio_test,
    input  i2s_pkg::pcm_in_t   pcm_left,
    input  i2s_pkg::pcm_in_t   pcm_right,
    output logic               credit_left,
    output logic               credit_right,
    output i2s_pkg::i2s_line_t i2s,
    output logic               underrun
);

    import i2s_pkg::*;

    pcm_sample_t left_head;
    pcm_sample_t right_head;
    logic        left_empty;
    logic        right_empty;
    logic        left_rd;
    logic        right_rd;
    level_t      right_level;
    logic        bclk;
    logic        bit_strobe;
    logic        fifo_clear;

    assign fifo_clear = !audio_en;                    // fifos empty while disabled

    sample_fifo u_left_fifo (
        .clk    (clk),
        .reset  (reset),
        .clear  (fifo_clear),
        .wr     (pcm_left),
        .rd     (left_rd),
        .head   (left_head),
        .empty  (left_empty),
        .level  (),                                   // only the right level starts the line
        .credit (credit_left)
    );

    sample_fifo u_right_fifo (
        .clk    (clk),
        .reset  (reset),
        .clear  (fifo_clear),
        .wr     (pcm_right),
        .rd     (right_rd),
        .head   (right_head),
        .empty  (right_empty),
        .level  (right_level),
        .credit (credit_right)
    );

    bit_clock_gen u_bit_clock_gen (
        .clk        (clk),
        .reset      (reset),
        .audio_en   (audio_en),
        .bclk       (bclk),
        .bit_strobe (bit_strobe)
    );

    i2s_serializer u_serializer (
        .clk         (clk),
        .reset       (reset),
        .audio_en    (audio_en),
        .audio_test  (audio_test),
        .bit_strobe  (bit_strobe),
        .bclk        (bclk),
        .left_head   (left_head),
        .right_head  (right_head),
        .left_empty  (left_empty),
        .right_empty (right_empty),
        .right_level (right_level),
        .left_rd     (left_rd),
        .right_rd    (right_rd),
        .i2s         (i2s),
        .underrun    (underrun)
    );

endmodule

//--- logic/sample_fifo.sv
module sample_fifo (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  i2s_pkg::pcm_in_t     wr,
    input  logic                 rd,
    output i2s_pkg::pcm_sample_t head,
    output logic                 empty,
    output i2s_pkg::level_t      level,
    output logic                 credit
);

    import i2s_pkg::*;

    pcm_sample_t          mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full  = (level == level_t'(fifo_depth));
    assign empty = (level == '0);

    assign push = wr.valid && !full;                  // write past full is dropped
    assign pop  = rd && !empty;                       // pop on empty is dropped

    // first word fall through
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.sample;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop;                            // one credit per word taken
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;              // wraps at fifo_depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;              // none or both
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module i2s_tx_tb -o Vi2s_tx_tb

output=$(./obj_dir/Vi2s_tx_tb)
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- sources.f
logic/i2s_pkg.sv
logic/sample_fifo.sv
logic/bit_clock_gen.sv
logic/i2s_serializer.sv
logic/i2s_tx_top.sv
dv/i2s_tx_tb.sv
